// ==== common/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

	////////////////////////////////////////
	// Sizes set by the instruction format
	////////////////////////////////////////
	localparam int XLEN        = 32;
	localparam int REG_ADDR_W  = 5;
	localparam int NUM_REGS    = 32;
	localparam int LINK_REG    = 31;
	localparam int PC_W        = 12;
	localparam int DMEM_ADDR_W = 8;
	localparam int OPCODE_W    = 5;
	localparam int SHAMT_W     = 5;
	localparam int ALU_OP_W    = 5;
	localparam int IMM_W       = 17;
	localparam int TARGET_W    = 27;

	// Opcodes
	localparam logic [OPCODE_W-1:0] OP_ALU  = 5'd0;
	localparam logic [OPCODE_W-1:0] OP_J    = 5'd1;
	localparam logic [OPCODE_W-1:0] OP_BNE  = 5'd2;
	localparam logic [OPCODE_W-1:0] OP_JAL  = 5'd3;
	localparam logic [OPCODE_W-1:0] OP_JR   = 5'd4;
	localparam logic [OPCODE_W-1:0] OP_ADDI = 5'd5;
	localparam logic [OPCODE_W-1:0] OP_BLT  = 5'd6;
	localparam logic [OPCODE_W-1:0] OP_SW   = 5'd7;
	localparam logic [OPCODE_W-1:0] OP_LW   = 5'd8;

	// ALU function codes
	localparam logic [ALU_OP_W-1:0] ALU_ADD = 5'd0;
	localparam logic [ALU_OP_W-1:0] ALU_SUB = 5'd1;
	localparam logic [ALU_OP_W-1:0] ALU_AND = 5'd2;
	localparam logic [ALU_OP_W-1:0] ALU_OR  = 5'd3;
	localparam logic [ALU_OP_W-1:0] ALU_SLL = 5'd4;
	localparam logic [ALU_OP_W-1:0] ALU_SRA = 5'd5;

	////////////////////////////////////////
	// Instruction word views
	////////////////////////////////////////
	typedef struct packed {
		logic [OPCODE_W-1:0]   opcode;
		logic [REG_ADDR_W-1:0] rd;
		logic [REG_ADDR_W-1:0] rs;
		logic [REG_ADDR_W-1:0] rt;
		logic [SHAMT_W-1:0]    shamt;
		logic [ALU_OP_W-1:0]   aluop;
		logic [1:0]            unused;
	} r_fmt_t;

	typedef struct packed {
		logic [OPCODE_W-1:0]   opcode;
		logic [REG_ADDR_W-1:0] rd;
		logic [REG_ADDR_W-1:0] rs;
		logic [IMM_W-1:0]      imm;
	} i_fmt_t;

	typedef struct packed {
		logic [OPCODE_W-1:0] opcode;
		logic [TARGET_W-1:0] target;
	} j_fmt_t;

	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		j_fmt_t j;
	} instr_t;

	// add r0, r0, r0
	localparam instr_t INSTR_NOP = '0;

endpackage

`default_nettype wire

// ==== common/pipe_if.sv ====
`timescale 1ns/10ps
`default_nettype none

// Decode to execute
interface id_ex_if
	import cpu_pkg::*;
();
	logic [PC_W-1:0]       pc_next;
	instr_t                instr;
	logic [XLEN-1:0]       rs_val;
	logic [XLEN-1:0]       rd_val;
	logic [XLEN-1:0]       imm;
	logic [REG_ADDR_W-1:0] b_idx;

	modport src (output pc_next, instr, rs_val, rd_val, imm, b_idx);
	modport dst (input  pc_next, instr, rs_val, rd_val, imm, b_idx);
endinterface

// Execute to memory
interface ex_mem_if
	import cpu_pkg::*;
();
	logic [PC_W-1:0] pc_next;
	instr_t          instr;
	logic [XLEN-1:0] alu_result;
	logic [XLEN-1:0] store_data;

	modport src (output pc_next, instr, alu_result, store_data);
	modport dst (input  pc_next, instr, alu_result, store_data);
endinterface

`default_nettype wire

// ==== execute/alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu
	import cpu_pkg::*;
(
	input  wire  [XLEN-1:0]      a,
	input  wire  [XLEN-1:0]      b,
	input  wire  [ALU_OP_W-1:0]  op,
	input  wire  [SHAMT_W-1:0]   shamt,
	output logic [XLEN-1:0]      result
);

	always_comb begin
		case (op)
			ALU_ADD: begin
				result = a + b;
			end
			ALU_SUB: begin
				result = a - b;
			end
			ALU_AND: begin
				result = a & b;
			end
			ALU_OR: begin
				result = a | b;
			end
			// Shifts act on operand a only
			ALU_SLL: begin
				result = a << shamt;
			end
			ALU_SRA: begin
				result = $signed(a) >>> shamt;
			end
			default: begin
				result = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== decode/reg_file.sv ====
`timescale 1ns/10ps
`default_nettype none

module reg_file
	import cpu_pkg::*;
(
	input  wire                    clock,
	input  wire                    arst_n,
	input  wire  [REG_ADDR_W-1:0]  rd_idx_a,
	input  wire  [REG_ADDR_W-1:0]  rd_idx_b,
	output logic [XLEN-1:0]        rd_val_a,
	output logic [XLEN-1:0]        rd_val_b,
	input  wire                    wb_en,
	input  wire  [REG_ADDR_W-1:0]  wb_reg,
	input  wire  [XLEN-1:0]        wb_data
);

	logic [XLEN-1:0] regs [NUM_REGS];
	logic            wr_live;

	// r0 stays zero
	assign wr_live = wb_en && (wb_reg != '0);

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_live) begin
			regs[wb_reg] <= wb_data;
		end
	end

	// Write-through so decode sees this cycle's writeback
	assign rd_val_a = (wr_live && (wb_reg == rd_idx_a)) ? wb_data : regs[rd_idx_a];
	assign rd_val_b = (wr_live && (wb_reg == rd_idx_b)) ? wb_data : regs[rd_idx_b];

endmodule

`default_nettype wire

// ==== source/fetch_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_stage
	import cpu_pkg::*;
(
	input  wire              clock,
	input  wire              arst_n,
	input  wire              stall,
	input  wire              redirect,
	input  wire  [PC_W-1:0]  redirect_pc,
	output logic [PC_W-1:0]  imem_addr,
	input  wire  [XLEN-1:0]  imem_data,
	output instr_t           ifid_instr,
	output logic [PC_W-1:0]  ifid_pc_next
);

	logic [PC_W-1:0] pc;
	logic [PC_W-1:0] pc_plus1;
	logic            advance;

	assign pc_plus1  = pc + 1'b1;
	assign imem_addr = pc;

	// A redirect overrides a stall
	assign advance = redirect || !stall;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			pc <= '0;
		end else if (redirect) begin
			pc <= redirect_pc;
		end else if (advance) begin
			pc <= pc_plus1;
		end
	end

	////////////////////////////////////////
	// IF/ID register
	////////////////////////////////////////
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			ifid_instr   <= INSTR_NOP;
			ifid_pc_next <= '0;
		end else if (advance) begin
			// Squash the wrong-path fetch
			ifid_instr   <= redirect ? INSTR_NOP : instr_t'(imem_data);
			ifid_pc_next <= pc_plus1;
		end
	end

	a_imem_addr_known: assert property (@(posedge clock) disable iff (!arst_n)
		!$isunknown(imem_addr));

endmodule

`default_nettype wire

// ==== decode/decode_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module decode_stage
	import cpu_pkg::*;
(
	input  wire                    clock,
	input  wire                    arst_n,
	input  wire instr_t            ifid_instr,
	input  wire  [PC_W-1:0]        ifid_pc_next,
	input  wire                    redirect,
	input  wire                    wb_en,
	input  wire  [REG_ADDR_W-1:0]  wb_reg,
	input  wire  [XLEN-1:0]        wb_data,
	output logic                   stall,
	id_ex_if.src                   id_ex
);

	logic [OPCODE_W-1:0]   op;
	logic [REG_ADDR_W-1:0] b_idx;
	logic [XLEN-1:0]       rs_val;
	logic [XLEN-1:0]       b_val;
	logic [XLEN-1:0]       imm;
	logic                  uses_rs;
	logic                  uses_b;
	logic                  load_in_ex;

	assign op = ifid_instr.i.opcode;

	// Branches, jr and sw read rd as their second source
	always_comb begin
		case (op)
			OP_BNE, OP_BLT, OP_JR, OP_SW: b_idx = ifid_instr.i.rd;
			default:                      b_idx = ifid_instr.r.rt;
		endcase
	end

	always_comb begin
		case (op)
			OP_ADDI, OP_LW, OP_SW, OP_BNE, OP_BLT:
				imm = {{(XLEN-IMM_W){ifid_instr.i.imm[IMM_W-1]}}, ifid_instr.i.imm};
			OP_J, OP_JAL:
				imm = {{(XLEN-TARGET_W){1'b0}}, ifid_instr.j.target};
			default:
				imm = '0;
		endcase
	end

	reg_file u_reg_file (
		.clock    (clock),
		.arst_n   (arst_n),
		.rd_idx_a (ifid_instr.i.rs),
		.rd_idx_b (b_idx),
		.rd_val_a (rs_val),
		.rd_val_b (b_val),
		.wb_en    (wb_en),
		.wb_reg   (wb_reg),
		.wb_data  (wb_data)
	);

	////////////////////////////////////////
	// Load-use hazard
	////////////////////////////////////////
	// Only count operands the instruction really reads
	assign uses_rs = (op == OP_ALU) || (op == OP_ADDI) || (op == OP_LW) ||
		(op == OP_BNE) || (op == OP_BLT);
	assign uses_b  = (op == OP_ALU) || (op == OP_BNE) || (op == OP_BLT) || (op == OP_JR);

	assign load_in_ex = (id_ex.instr.i.opcode == OP_LW) && (id_ex.instr.i.rd != '0);

	// sw data is patched in the memory stage instead
	assign stall = load_in_ex && (op != OP_SW) &&
		((uses_rs && (id_ex.instr.i.rd == ifid_instr.i.rs)) ||
		 (uses_b && (id_ex.instr.i.rd == b_idx)));

	// ID/EX register with a bubble on stall or squash
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			id_ex.pc_next <= '0;
			id_ex.instr   <= INSTR_NOP;
			id_ex.rs_val  <= '0;
			id_ex.rd_val  <= '0;
			id_ex.imm     <= '0;
			id_ex.b_idx   <= '0;
		end else if (stall || redirect) begin
			id_ex.pc_next <= '0;
			id_ex.instr   <= INSTR_NOP;
			id_ex.rs_val  <= '0;
			id_ex.rd_val  <= '0;
			id_ex.imm     <= '0;
			id_ex.b_idx   <= '0;
		end else begin
			id_ex.pc_next <= ifid_pc_next;
			id_ex.instr   <= ifid_instr;
			id_ex.rs_val  <= rs_val;
			id_ex.rd_val  <= b_val;
			id_ex.imm     <= imm;
			id_ex.b_idx   <= b_idx;
		end
	end

endmodule

`default_nettype wire

// ==== execute/execute_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module execute_stage
	import cpu_pkg::*;
(
	input  wire                    clock,
	input  wire                    arst_n,
	id_ex_if.dst                   id_ex,
	ex_mem_if.src                  ex_mem,
	input  wire                    wb_en,
	input  wire  [REG_ADDR_W-1:0]  wb_reg,
	input  wire  [XLEN-1:0]        wb_data,
	output logic                   redirect,
	output logic [PC_W-1:0]        redirect_pc
);

	logic [OPCODE_W-1:0] op;
	logic                mem_fwd;
	logic                use_imm;
	logic                bne_taken;
	logic                blt_taken;
	logic [XLEN-1:0]     opnd_a;
	logic [XLEN-1:0]     opnd_b_reg;
	logic [XLEN-1:0]     opnd_b;
	logic [XLEN-1:0]     alu_out;
	logic [ALU_OP_W-1:0] alu_code;

	// EX/MEM has priority over writeback and writeback over the register file
	function automatic logic [XLEN-1:0] forward(
		input logic [REG_ADDR_W-1:0] idx,
		input logic [XLEN-1:0]       reg_val
	);
		logic [XLEN-1:0] val;
		val = reg_val;
		if (wb_en && (wb_reg == idx)) val = wb_data;
		if (mem_fwd && (ex_mem.instr.i.rd == idx)) val = ex_mem.alu_result;
		return val;
	endfunction

	assign op = id_ex.instr.i.opcode;

	// Only ALU and addi results are final in EX/MEM
	assign mem_fwd = ((ex_mem.instr.i.opcode == OP_ALU) || (ex_mem.instr.i.opcode == OP_ADDI))
		&& (ex_mem.instr.i.rd != '0);

	always_comb begin
		opnd_a     = forward(id_ex.instr.i.rs, id_ex.rs_val);
		opnd_b_reg = forward(id_ex.b_idx, id_ex.rd_val);
	end

	assign use_imm  = (op == OP_ADDI) || (op == OP_LW) || (op == OP_SW);
	assign opnd_b   = use_imm ? id_ex.imm : opnd_b_reg;
	assign alu_code = use_imm ? ALU_ADD : id_ex.instr.r.aluop;

	alu u_alu (
		.a      (opnd_a),
		.b      (opnd_b),
		.op     (alu_code),
		.shamt  (id_ex.instr.r.shamt),
		.result (alu_out)
	);

	////////////////////////////////////////
	// Branch and jump resolution
	////////////////////////////////////////
	assign bne_taken = (op == OP_BNE) && (opnd_b_reg != opnd_a);
	assign blt_taken = (op == OP_BLT) && ($signed(opnd_b_reg) < $signed(opnd_a));

	assign redirect = (op == OP_J) || (op == OP_JAL) || (op == OP_JR) || bne_taken || blt_taken;

	always_comb begin
		case (op)
			OP_J, OP_JAL: redirect_pc = id_ex.imm[PC_W-1:0];
			OP_JR:        redirect_pc = opnd_b_reg[PC_W-1:0];
			default:      redirect_pc = id_ex.pc_next + id_ex.imm[PC_W-1:0];
		endcase
	end

	// EX/MEM register
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			ex_mem.pc_next    <= '0;
			ex_mem.instr      <= INSTR_NOP;
			ex_mem.alu_result <= '0;
			ex_mem.store_data <= '0;
		end else begin
			ex_mem.pc_next    <= id_ex.pc_next;
			ex_mem.instr      <= id_ex.instr;
			ex_mem.alu_result <= alu_out;
			ex_mem.store_data <= opnd_b_reg;
		end
	end

	// A redirect always leaves a bubble behind in ID/EX
	a_bubble_after_redirect: assert property (@(posedge clock) disable iff (!arst_n)
		redirect |=> (id_ex.instr == INSTR_NOP));

endmodule

`default_nettype wire

// ==== source/memory_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module memory_stage
	import cpu_pkg::*;
(
	input  wire                     clock,
	input  wire                     arst_n,
	ex_mem_if.dst                   ex_mem,
	output logic                    store_en,
	output logic [DMEM_ADDR_W-1:0]  store_addr,
	output logic [XLEN-1:0]         store_data,
	output logic                    wb_en,
	output logic [REG_ADDR_W-1:0]   wb_reg,
	output logic [XLEN-1:0]         wb_data
);

	logic [XLEN-1:0]        dmem [2**DMEM_ADDR_W];
	logic [OPCODE_W-1:0]    op;
	logic [DMEM_ADDR_W-1:0] mem_idx;
	logic [XLEN-1:0]        load_data;
	logic [REG_ADDR_W-1:0]  dest;
	logic                   writes;
	logic [XLEN-1:0]        result;

	assign op      = ex_mem.instr.i.opcode;
	assign mem_idx = ex_mem.alu_result[DMEM_ADDR_W-1:0];

	// A lw then sw of the same register stores the loaded value
	assign store_en   = (op == OP_SW);
	assign store_addr = mem_idx;
	assign store_data = (wb_en && (wb_reg == ex_mem.instr.i.rd)) ? wb_data : ex_mem.store_data;

	always_ff @(posedge clock) begin
		if (store_en) begin
			dmem[mem_idx] <= store_data;
		end
	end

	assign load_data = dmem[mem_idx];

	////////////////////////////////////////
	// Writeback select and MEM/WB
	////////////////////////////////////////
	assign writes = (op == OP_ALU) || (op == OP_ADDI) || (op == OP_LW) || (op == OP_JAL);
	assign dest   = (op == OP_JAL) ? REG_ADDR_W'(LINK_REG) : ex_mem.instr.i.rd;
	assign result = (op == OP_LW)  ? load_data :
	                (op == OP_JAL) ? {{(XLEN-PC_W){1'b0}}, ex_mem.pc_next} :
	                ex_mem.alu_result;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			wb_en   <= 1'b0;
			wb_reg  <= '0;
			wb_data <= '0;
		end else begin
			wb_en   <= writes && (dest != '0);
			wb_reg  <= dest;
			wb_data <= result;
		end
	end

	// Loads only read words that a store has written
	a_load_data_known: assert property (@(posedge clock) disable iff (!arst_n)
		(op == OP_LW) |-> !$isunknown(load_data));

endmodule

`default_nettype wire

// ==== source/cpu_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module cpu_top
	import cpu_pkg::*;
(
	input  wire                     clock,
	input  wire                     arst_n,
	output logic [PC_W-1:0]         imem_addr,
	input  wire  [XLEN-1:0]         imem_data,
	output logic                    wb_en,
	output logic [REG_ADDR_W-1:0]   wb_reg,
	output logic [XLEN-1:0]         wb_data,
	output logic                    store_en,
	output logic [DMEM_ADDR_W-1:0]  store_addr,
	output logic [XLEN-1:0]         store_data
);

	logic            stall;
	logic            redirect;
	logic [PC_W-1:0] redirect_pc;
	instr_t          ifid_instr;
	logic [PC_W-1:0] ifid_pc_next;

	id_ex_if  u_id_ex ();
	ex_mem_if u_ex_mem ();

	fetch_stage u_fetch (
		.clock        (clock),
		.arst_n       (arst_n),
		.stall        (stall),
		.redirect     (redirect),
		.redirect_pc  (redirect_pc),
		.imem_addr    (imem_addr),
		.imem_data    (imem_data),
		.ifid_instr   (ifid_instr),
		.ifid_pc_next (ifid_pc_next)
	);

	decode_stage u_decode (
		.clock        (clock),
		.arst_n       (arst_n),
		.ifid_instr   (ifid_instr),
		.ifid_pc_next (ifid_pc_next),
		.redirect     (redirect),
		.wb_en        (wb_en),
		.wb_reg       (wb_reg),
		.wb_data      (wb_data),
		.stall        (stall),
		.id_ex        (u_id_ex.src)
	);

	execute_stage u_execute (
		.clock        (clock),
		.arst_n       (arst_n),
		.id_ex        (u_id_ex.dst),
		.ex_mem       (u_ex_mem.src),
		.wb_en        (wb_en),
		.wb_reg       (wb_reg),
		.wb_data      (wb_data),
		.redirect     (redirect),
		.redirect_pc  (redirect_pc)
	);

	memory_stage u_memory (
		.clock        (clock),
		.arst_n       (arst_n),
		.ex_mem       (u_ex_mem.dst),
		.store_en     (store_en),
		.store_addr   (store_addr),
		.store_data   (store_data),
		.wb_en        (wb_en),
		.wb_reg       (wb_reg),
		.wb_data      (wb_data)
	);

endmodule

`default_nettype wire

// ==== tests/cpu_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module cpu_tb
	import cpu_pkg::*;
;

	localparam int CLK_PERIOD   = 100;
	localparam int DRAIN_CYCLES = 8;
	// Program words of the five tests are 3, 17, 19, 19 and 13
	localparam int TOTAL_PROG_WORDS = 71;

	logic                   clock;
	logic                   arst_n;
	logic [PC_W-1:0]        imem_addr;
	logic [XLEN-1:0]        imem_data;
	logic                   wb_en;
	logic [REG_ADDR_W-1:0]  wb_reg;
	logic [XLEN-1:0]        wb_data;
	logic                   store_en;
	logic [DMEM_ADDR_W-1:0] store_addr;
	logic [XLEN-1:0]        store_data;

	logic [XLEN-1:0] prog [2**PC_W];
	int              wr_ptr;
	logic [31:0]     rng_state;
	int              cycle;
	int              first_wb_cycle;
	logic [PC_W-1:0] start_addr;

	logic [31:0] exp_wb_reg[$];
	logic [31:0] exp_wb_val[$];
	logic [31:0] exp_st_addr[$];
	logic [31:0] exp_st_data[$];
	logic [31:0] got_wb_reg[$];
	logic [31:0] got_wb_val[$];
	logic [31:0] got_st_addr[$];
	logic [31:0] got_st_data[$];

	cpu_top u_dut (
		.clock      (clock),
		.arst_n     (arst_n),
		.imem_addr  (imem_addr),
		.imem_data  (imem_data),
		.wb_en      (wb_en),
		.wb_reg     (wb_reg),
		.wb_data    (wb_data),
		.store_en   (store_en),
		.store_addr (store_addr),
		.store_data (store_data)
	);

	// Instruction memory model with a combinational read
	assign imem_data = prog[imem_addr];

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	// Event monitor that records the cycle ending at this edge
	always @(posedge clock) begin
		if (arst_n) begin
			if (cycle == 0) begin
				start_addr = imem_addr;
			end
			if (wb_en) begin
				if (got_wb_reg.size() == 0) begin
					first_wb_cycle = cycle;
				end
				got_wb_reg.push_back(32'(wb_reg));
				got_wb_val.push_back(wb_data);
			end
			if (store_en) begin
				got_st_addr.push_back(32'(store_addr));
				got_st_data.push_back(store_data);
			end
			cycle++;
		end
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////
	function automatic logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function automatic logic [31:0] sext17(input logic [31:0] v);
		return {{15{v[16]}}, v[16:0]};
	endfunction

	function automatic logic [31:0] alu_word(input logic [ALU_OP_W-1:0] fn, input int rd,
		input int rs, input int rt, input int shamt);
		return {OP_ALU, rd[4:0], rs[4:0], rt[4:0], shamt[4:0], fn, 2'b00};
	endfunction

	function automatic logic [31:0] imm_word(input logic [OPCODE_W-1:0] op, input int rd,
		input int rs, input int imm);
		return {op, rd[4:0], rs[4:0], imm[16:0]};
	endfunction

	function automatic logic [31:0] jump_word(input logic [OPCODE_W-1:0] op, input int target);
		return {op, target[26:0]};
	endfunction

	task automatic emit(input logic [31:0] word);
		prog[wr_ptr] = word;
		wr_ptr++;
	endtask

	// A jump to itself idles the pipeline without writes
	task automatic emit_halt();
		emit(jump_word(OP_J, wr_ptr));
	endtask

	task automatic expect_wb(input int r, input logic [31:0] v);
		exp_wb_reg.push_back(32'(r));
		exp_wb_val.push_back(v);
	endtask

	task automatic expect_store(input int addr, input logic [31:0] v);
		exp_st_addr.push_back(32'(addr));
		exp_st_data.push_back(v);
	endtask

	task automatic stop_with_errors();
		$display("Finished with errors");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check(input string name, input logic [31:0] expected, input logic [31:0] actual);
		if (actual !== expected) begin
			$display("ERR time %0t signal %s expected %h actual %h", $time, name, expected, actual);
			stop_with_errors();
		end
	endtask

	task automatic clear_program();
		for (int i = 0; i < 2**PC_W; i++) begin
			prog[i] = '0;
		end
		wr_ptr = 0;
	endtask

	task automatic hold_reset();
		@(negedge clock);
		arst_n = 1'b0;
		clear_program();
		cycle          = 0;
		first_wb_cycle = -1;
		exp_wb_reg.delete();
		exp_wb_val.delete();
		exp_st_addr.delete();
		exp_st_data.delete();
		got_wb_reg.delete();
		got_wb_val.delete();
		got_st_addr.delete();
		got_st_data.delete();
	endtask

	// Finish reset, wait for all events, then compare in order
	task automatic run_program();
		repeat (3) begin
			@(negedge clock);
			check("imem_addr", 32'd0, 32'(imem_addr));
			check("wb_en", 32'd0, 32'(wb_en));
			check("store_en", 32'd0, 32'(store_en));
		end
		arst_n = 1'b1;
		while ((got_wb_reg.size() < exp_wb_reg.size()) ||
			(got_st_addr.size() < exp_st_addr.size())) begin
			@(negedge clock);
		end
		repeat (DRAIN_CYCLES) @(negedge clock);
		check("wb_en event count", exp_wb_reg.size(), got_wb_reg.size());
		check("store_en event count", exp_st_addr.size(), got_st_addr.size());
		foreach (exp_wb_reg[i]) begin
			check("wb_reg", exp_wb_reg[i], got_wb_reg[i]);
			check("wb_data", exp_wb_val[i], got_wb_val[i]);
		end
		foreach (exp_st_addr[i]) begin
			check("store_addr", exp_st_addr[i], got_st_addr[i]);
			check("store_data", exp_st_data[i], got_st_data[i]);
		end
	endtask

	////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////
	task automatic test_reset_and_first_write();
		hold_reset();
		emit(imm_word(OP_ADDI, 1, 0, 5));
		expect_wb(1, 32'd5);
		emit(imm_word(OP_ADDI, 2, 1, 7));
		expect_wb(2, 32'd12);
		emit_halt();
		run_program();
		check("imem_addr at first cycle", 32'd0, 32'(start_addr));
		check("first wb_en cycle", 32'd4, 32'(first_wb_cycle));
	endtask

	task automatic test_alu_forwarding();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] add_r;
		logic [31:0] sub_r;
		logic [31:0] and_r;
		logic [31:0] or_r;
		logic [31:0] sll_r;
		logic [31:0] sra_r;
		int          sh1;
		int          sh2;
		hold_reset();
		repeat (2) begin
			a     = sext17(next_random());
			b     = sext17(next_random());
			sh1   = int'(next_random() & 32'h1f);
			sh2   = int'(next_random() & 32'h1f);
			add_r = a + b;
			sub_r = add_r - a;
			and_r = sub_r & b;
			or_r  = and_r | add_r;
			sll_r = or_r << sh1;
			sra_r = $signed(sll_r) >>> sh2;
			emit(imm_word(OP_ADDI, 1, 0, int'(a)));
			expect_wb(1, a);
			emit(imm_word(OP_ADDI, 2, 0, int'(b)));
			expect_wb(2, b);
			emit(alu_word(ALU_ADD, 3, 1, 2, 0));
			expect_wb(3, add_r);
			emit(alu_word(ALU_SUB, 4, 3, 1, 0));
			expect_wb(4, sub_r);
			emit(alu_word(ALU_AND, 5, 4, 2, 0));
			expect_wb(5, and_r);
			emit(alu_word(ALU_OR, 6, 5, 3, 0));
			expect_wb(6, or_r);
			emit(alu_word(ALU_SLL, 7, 6, 0, sh1));
			expect_wb(7, sll_r);
			emit(alu_word(ALU_SRA, 8, 7, 0, sh2));
			expect_wb(8, sra_r);
		end
		emit_halt();
		run_program();
	endtask

	task automatic test_load_store();
		logic [31:0] v [4];
		hold_reset();
		for (int i = 0; i < 4; i++) begin
			v[i] = sext17(next_random());
			emit(imm_word(OP_ADDI, i + 1, 0, int'(v[i])));
			expect_wb(i + 1, v[i]);
		end
		for (int i = 0; i < 4; i++) begin
			emit(imm_word(OP_SW, i + 1, 0, 16 + i));
			expect_store(16 + i, v[i]);
		end
		// Each load feeds the next instruction
		emit(imm_word(OP_LW, 5, 0, 16));
		expect_wb(5, v[0]);
		emit(alu_word(ALU_ADD, 6, 5, 2, 0));
		expect_wb(6, v[0] + v[1]);
		emit(imm_word(OP_LW, 7, 0, 17));
		expect_wb(7, v[1]);
		emit(alu_word(ALU_ADD, 8, 7, 7, 0));
		expect_wb(8, v[1] + v[1]);
		emit(imm_word(OP_LW, 9, 0, 18));
		expect_wb(9, v[2]);
		emit(alu_word(ALU_ADD, 10, 9, 4, 0));
		expect_wb(10, v[2] + v[3]);
		emit(imm_word(OP_LW, 11, 0, 19));
		expect_wb(11, v[3]);
		emit(alu_word(ALU_ADD, 12, 1, 11, 0));
		expect_wb(12, v[0] + v[3]);
		emit(imm_word(OP_LW, 13, 0, 16));
		expect_wb(13, v[0]);
		emit(imm_word(OP_SW, 13, 0, 20));
		expect_store(20, v[0]);
		emit_halt();
		run_program();
	endtask

	task automatic test_branches();
		hold_reset();
		emit(imm_word(OP_ADDI, 1, 0, 5));
		expect_wb(1, 32'd5);
		emit(imm_word(OP_ADDI, 2, 0, -3));
		expect_wb(2, -3);
		emit(imm_word(OP_BNE, 1, 1, 2));
		emit(imm_word(OP_ADDI, 3, 0, 1));
		expect_wb(3, 32'd1);
		emit(imm_word(OP_BNE, 1, 2, 2));
		emit(imm_word(OP_ADDI, 4, 0, 99));
		emit(imm_word(OP_ADDI, 4, 0, 98));
		emit(imm_word(OP_ADDI, 5, 0, 2));
		expect_wb(5, 32'd2);
		// -3 < 5 taken, then 5 < -3 falls through
		emit(imm_word(OP_BLT, 2, 1, 2));
		emit(imm_word(OP_ADDI, 6, 0, 99));
		emit(imm_word(OP_ADDI, 6, 0, 98));
		emit(imm_word(OP_ADDI, 7, 0, 3));
		expect_wb(7, 32'd3);
		emit(imm_word(OP_BLT, 1, 2, 2));
		emit(imm_word(OP_ADDI, 8, 0, 4));
		expect_wb(8, 32'd4);
		emit(imm_word(OP_ADDI, 9, 0, -7));
		expect_wb(9, -7);
		emit(imm_word(OP_BLT, 9, 2, 1));
		emit(imm_word(OP_ADDI, 10, 0, 99));
		emit(imm_word(OP_ADDI, 11, 0, 6));
		expect_wb(11, 32'd6);
		emit_halt();
		run_program();
	endtask

	task automatic test_jumps();
		hold_reset();
		emit(imm_word(OP_ADDI, 1, 0, 1));
		expect_wb(1, 32'd1);
		emit(jump_word(OP_J, 4));
		emit(imm_word(OP_ADDI, 2, 0, 99));
		emit(imm_word(OP_ADDI, 2, 0, 98));
		emit(jump_word(OP_JAL, 9));
		expect_wb(31, 32'd5);
		// Return point of the call
		emit(imm_word(OP_ADDI, 3, 0, 3));
		emit(imm_word(OP_ADDI, 0, 0, 7));
		emit(imm_word(OP_ADDI, 4, 0, 4));
		emit_halt();
		emit(imm_word(OP_ADDI, 5, 0, 5));
		expect_wb(5, 32'd5);
		expect_wb(3, 32'd3);
		expect_wb(4, 32'd4);
		emit(imm_word(OP_JR, 31, 0, 0));
		emit(imm_word(OP_ADDI, 6, 0, 99));
		emit(imm_word(OP_ADDI, 6, 0, 98));
		run_program();
	endtask

	initial begin
		arst_n         = 1'b0;
		rng_state      = 32'hd3f0d7cf;
		cycle          = 0;
		first_wb_cycle = -1;
		start_addr     = '0;
		clear_program();
		test_reset_and_first_write();
		test_alu_forwarding();
		test_load_store();
		test_branches();
		test_jumps();
		$display("Finished with no errors");
		$finish;
	end

	// Watchdog
	initial begin
		repeat (TOTAL_PROG_WORDS * 20) @(posedge clock);
		$display("Watchdog expired after %0d cycles, the tests did not complete",
			TOTAL_PROG_WORDS * 20);
		stop_with_errors();
	end

endmodule

`default_nettype wire

// ==== src.f ====
common/cpu_pkg.sv
common/pipe_if.sv
execute/alu.sv
decode/reg_file.sv
source/fetch_stage.sv
decode/decode_stage.sv
execute/execute_stage.sv
source/memory_stage.sv
source/cpu_top.sv
tests/cpu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= cpu_tb
FLAGS     ?= --binary --assert -Wno-fatal
OBJ_DIR   ?= obj_dir

SOURCES := $(filter-out +%,$(shell cat src.f))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): src.f $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f src.f

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
